// ==== files.f ====
hw/mipsPkg.sv
hw/instrClassifier.sv
hw/storeForward.sv
hw/dataMemory.sv
hw/memWbRegister.sv
hw/memStage.sv
dv/memStageAsserts.sv
dv/memStageTb.sv

// ==== dv/memStageTb.sv ====
/*
 * Random and directed stimulus for the memory stage.
 * The bound assertion module does the checking; its count is read at the end.
 * Inputs stay in place for the cycle that follows a stall.
 */

module memStageTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 3;
    localparam int instrCount  = 400;
    // Half as much time again as the nominal run needs.
    localparam int timeoutNs   = (resetCycles + instrCount + 50) * clkPeriod * 3 / 2;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        clr;
    logic [31:0] instrMem;
    logic [31:0] pcMem;
    logic [31:0] aluOutMem;
    logic [31:0] memWriteDataMem;
    logic [4:0]  regWriteAddrMem;
    logic [31:0] regWriteDataMem;
    logic [4:0]  regAddrWb;
    logic [31:0] regDataWb;
    logic [31:0] instrWb;
    logic [31:0] pcWb;
    logic [31:0] memReadDataWb;
    logic [4:0]  regWriteAddrWb;
    logic [31:0] regWriteDataWb;

    integer      seed = 32'h2b39dd14;
    logic [31:0] pc;
    logic [5:0]  storeOps [3] = '{mipsPkg::opSb, mipsPkg::opSh, mipsPkg::opSw};
    logic [5:0]  loadOps [3]  = '{mipsPkg::opLb, mipsPkg::opLh, mipsPkg::opLw};

    memStage #(.memDepthWords(256)) DUT (
        .clk(clk), .reset(reset), .stall(stall), .clr(clr),
        .instrMem(instrMem), .pcMem(pcMem), .aluOutMem(aluOutMem),
        .memWriteDataMem(memWriteDataMem), .regWriteAddrMem(regWriteAddrMem),
        .regWriteDataMem(regWriteDataMem), .regAddrWb(regAddrWb), .regDataWb(regDataWb),
        .instrWb(instrWb), .pcWb(pcWb), .memReadDataWb(memReadDataWb),
        .regWriteAddrWb(regWriteAddrWb), .regWriteDataWb(regWriteDataWb)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Eight memory opcodes plus four that the stage must pass through.
    function automatic logic [5:0] pickOpcode(input int choice);
        case (choice)
            0: return mipsPkg::opLw;
            1: return mipsPkg::opLh;
            2: return mipsPkg::opLhu;
            3: return mipsPkg::opLb;
            4: return mipsPkg::opLbu;
            5: return mipsPkg::opSw;
            6: return mipsPkg::opSh;
            7: return mipsPkg::opSb;
            8: return 6'h00;
            9: return 6'h08;
            10: return 6'h0d;
            default: return 6'h04;
        endcase
    endfunction

    // Presents one instruction at a rising edge; a stalled one stays for one more cycle.
    task automatic issue(input logic [5:0] op, input logic [4:0] rt, input logic [31:0] addr,
                         input logic [31:0] storeValue, input logic [4:0] wbAddr,
                         input logic [31:0] wbData, input logic holdCycle,
                         input logic squash);
        @(posedge clk);
        instrMem        <= {op, 5'($random(seed)), rt, 16'($random(seed))};
        pcMem           <= pc;
        aluOutMem       <= addr;
        memWriteDataMem <= storeValue;
        regWriteAddrMem <= 5'($random(seed));
        regWriteDataMem <= $random(seed);
        regAddrWb       <= wbAddr;
        regDataWb       <= wbData;
        stall           <= holdCycle;
        clr             <= squash;
        pc = pc + 32'd4;
        if (holdCycle) begin
            @(posedge clk);
            stall <= 1'b0;
        end
    endtask

    initial begin
        logic [4:0]  rt;
        logic [4:0]  wbAddr;
        logic [5:0]  op;
        logic [31:0] addr;
        logic [31:0] storeValue;
        logic [31:0] wbData;
        logic        holdCycle;
        logic        squash;
        reset <= 1'b1;
        stall <= 1'b0;
        clr <= 1'b0;
        instrMem <= '0;
        pcMem <= '0;
        aluOutMem <= '0;
        memWriteDataMem <= '0;
        regWriteAddrMem <= '0;
        regWriteDataMem <= '0;
        regAddrWb <= '0;
        regDataWb <= '0;
        pc = 32'h0040_0000;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;

        for (int n = 0; n < instrCount; n++) begin
            rt = 5'($random(seed));
            case ($unsigned($random(seed)) % 4)
                0: wbAddr = rt;
                1: wbAddr = 5'd0;
                default: wbAddr = 5'($random(seed));
            endcase
            op = pickOpcode($unsigned($random(seed)) % 12);
            // Index bits 5:2 stay in a 16-word window; bits above the depth wrap.
            addr = $random(seed) & 32'hffff_fc3f;
            storeValue = $random(seed);
            wbData = $random(seed);
            holdCycle = ($unsigned($random(seed)) % 8) == 0;
            squash = ($unsigned($random(seed)) % 16) == 0;
            issue(op, rt, addr, storeValue, wbAddr, wbData, holdCycle, squash);
        end

        // Store then load per size, first with rt forwarded, then with register 0 in WB.
        for (int k = 0; k < 6; k++) begin
            addr = 32'h100 + 16 * k + 3;
            wbAddr = (k < 3) ? 5'd9 : 5'd0;
            issue(storeOps[k % 3], 5'd9, addr, 32'h7e5a_2b4c, wbAddr, 32'hc3a5_9681,
                  1'b0, 1'b0);
            issue(loadOps[k % 3], 5'd9, addr, '0, 5'd0, '0, 1'b0, 1'b0);
        end

        // The last load is checked at the second edge, and its result settles by the falling edge.
        repeat (2) @(posedge clk);
        @(negedge clk);
        $display("Assertion failures: %0d", DUT.stageChecks.failCount);
        if (DUT.stageChecks.failCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Watchdog expired before the stimulus finished");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== dv/memStageAsserts.sv ====
/*
 * Bound checker for the memory stage. It keeps a shadow memory of its own.
 * The shadow follows the store and forwarding rules and is cleared by reset.
 * Failures are counted in failCount, which the testbench reads at the end.
 */

module memStageAsserts #(
    parameter int memDepthWords = 256
) (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        clr,
    input logic [31:0] instrMem,
    input logic [31:0] pcMem,
    input logic [31:0] aluOutMem,
    input logic [31:0] memWriteDataMem,
    input logic [4:0]  regWriteAddrMem,
    input logic [31:0] regWriteDataMem,
    input logic [4:0]  regAddrWb,
    input logic [31:0] regDataWb,
    input logic [31:0] instrWb,
    input logic [31:0] pcWb,
    input logic [31:0] memReadDataWb,
    input logic [4:0]  regWriteAddrWb,
    input logic [31:0] regWriteDataWb
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int indexWidth = $clog2(memDepthWords);

    int failCount = 0;

    logic [31:0]           shadow [memDepthWords];
    logic [5:0]            opcode;
    logic [indexWidth-1:0] index;
    logic                  isLoad;
    logic                  isStore;
    logic [31:0]           storeValue;
    logic [31:0]           expectedLoad;

    // Picks the loaded piece of a word and extends it as the opcode says.
    function automatic logic [31:0] extractLoad(input logic [31:0] word,
                                                input logic [1:0] lowAddr,
                                                input logic [5:0] op);
        logic [7:0]  pickedByte;
        logic [15:0] pickedHalf;
        pickedByte = 8'(word >> (8 * lowAddr));
        pickedHalf = lowAddr[1] ? word[31:16] : word[15:0];
        case (op)
            mipsPkg::opLb:  return {{24{pickedByte[7]}}, pickedByte};
            mipsPkg::opLbu: return {24'h0, pickedByte};
            mipsPkg::opLh:  return {{16{pickedHalf[15]}}, pickedHalf};
            mipsPkg::opLhu: return {16'h0, pickedHalf};
            default:        return word;
        endcase
    endfunction

    assign opcode  = instrMem[31:26];
    assign index   = aluOutMem[2 +: indexWidth];
    assign isLoad  = opcode inside {mipsPkg::opLw, mipsPkg::opLh, mipsPkg::opLhu,
                                    mipsPkg::opLb, mipsPkg::opLbu};
    assign isStore = opcode inside {mipsPkg::opSw, mipsPkg::opSh, mipsPkg::opSb};

    // The newest value of rt comes from write-back unless rt is register 0.
    assign storeValue = (isStore && regAddrWb != 5'd0 && regAddrWb == instrMem[20:16])
                      ? regDataWb : memWriteDataMem;

    // Built from the shadow as it stands before this edge's store.
    assign expectedLoad = extractLoad(shadow[index], aluOutMem[1:0], opcode);

    // A stalled store is skipped here, so a later load exposes it if the DUT wrote it.
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < memDepthWords; i++) begin
                shadow[i] <= '0;
            end
        end else if (isStore && !stall) begin
            case (opcode)
                mipsPkg::opSb: shadow[index][8 * aluOutMem[1:0] +: 8] <= storeValue[7:0];
                mipsPkg::opSh: shadow[index][16 * aluOutMem[1] +: 16] <= storeValue[15:0];
                default:       shadow[index] <= storeValue;
            endcase
        end
    end

    clearedOutputs: assert property (@(posedge clk) (reset || clr) |=>
        (instrWb == '0 && pcWb == '0 && memReadDataWb == '0 &&
         regWriteAddrWb == '0 && regWriteDataWb == '0))
    else begin
        failCount++;
        $error("Mismatch at %0t: outputs not zero after reset or clr", $time);
    end

    heldOnStall: assert property (@(posedge clk) (stall && !reset && !clr) |=>
        (instrWb == $past(instrWb) && pcWb == $past(pcWb) &&
         memReadDataWb == $past(memReadDataWb) &&
         regWriteAddrWb == $past(regWriteAddrWb) &&
         regWriteDataWb == $past(regWriteDataWb)))
    else begin
        failCount++;
        $error("Mismatch at %0t: outputs changed during stall", $time);
    end

    passThrough: assert property (@(posedge clk) (!reset && !clr && !stall && !isLoad) |=>
        (instrWb == $past(instrMem) && pcWb == $past(pcMem) &&
         regWriteAddrWb == $past(regWriteAddrMem) &&
         regWriteDataWb == $past(regWriteDataMem)))
    else begin
        failCount++;
        $error("Mismatch at %0t: non-load fields not carried into WB", $time);
    end

    // Forwarded and unforwarded stores both surface here through the shadow.
    loadResult: assert property (@(posedge clk) (!reset && !clr && !stall && isLoad) |=>
        (regWriteDataWb == memReadDataWb && regWriteDataWb == $past(expectedLoad)))
    else begin
        failCount++;
        $error("Mismatch at %0t: load gave %h, shadow expects %h", $time,
               regWriteDataWb, $past(expectedLoad));
    end

endmodule

bind memStage memStageAsserts #(.memDepthWords(memDepthWords)) stageChecks (.*);

// ==== hw/memStage.sv ====
/*
 * Memory-access stage of the five-stage pipeline with its MEM/WB register.
 * stall and clr are plain levels and there is no handshake.
 * The upstream stage must hold its inputs while stall is high.
 * memDepthWords must be a power of two.
 */

module memStage #(
    parameter int memDepthWords = 256
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stall,
    input  logic                             clr,
    input  logic [mipsPkg::instrWidth-1:0]   instrMem,
    input  logic [mipsPkg::dataWidth-1:0]    pcMem,
    input  logic [mipsPkg::dataWidth-1:0]    aluOutMem,
    input  logic [mipsPkg::dataWidth-1:0]    memWriteDataMem,
    input  logic [mipsPkg::regAddrWidth-1:0] regWriteAddrMem,
    input  logic [mipsPkg::dataWidth-1:0]    regWriteDataMem,
    input  logic [mipsPkg::regAddrWidth-1:0] regAddrWb,
    input  logic [mipsPkg::dataWidth-1:0]    regDataWb,
    output logic [mipsPkg::instrWidth-1:0]   instrWb,
    output logic [mipsPkg::dataWidth-1:0]    pcWb,
    output logic [mipsPkg::dataWidth-1:0]    memReadDataWb,
    output logic [mipsPkg::regAddrWidth-1:0] regWriteAddrWb,
    output logic [mipsPkg::dataWidth-1:0]    regWriteDataWb
);

    mipsPkg::memClass              memKind;
    mipsPkg::accessSize            accessKind;
    logic                          loadSigned;
    logic [mipsPkg::dataWidth-1:0] storeData;
    logic [mipsPkg::dataWidth-1:0] readData;

    // Decode and forwarding both look at the same instruction in parallel.
    instrClassifier classifier (
        .instr      (instrMem),
        .memKind    (memKind),
        .accessKind (accessKind),
        .loadSigned (loadSigned)
    );

    storeForward forward (
        .instr        (instrMem),
        .memKind      (memKind),
        .memWriteData (memWriteDataMem),
        .regAddrWb    (regAddrWb),
        .regDataWb    (regDataWb),
        .storeData    (storeData)
    );

    // The ALU result is the effective address.
    dataMemory #(
        .memDepthWords (memDepthWords)
    ) memory (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .memKind    (memKind),
        .accessKind (accessKind),
        .loadSigned (loadSigned),
        .addr       (aluOutMem),
        .storeData  (storeData),
        .readData   (readData)
    );

    memWbRegister pipeReg (
        .clk             (clk),
        .reset           (reset),
        .stall           (stall),
        .clr             (clr),
        .memKind         (memKind),
        .instrMem        (instrMem),
        .pcMem           (pcMem),
        .readData        (readData),
        .regWriteAddrMem (regWriteAddrMem),
        .regWriteDataMem (regWriteDataMem),
        .instrWb         (instrWb),
        .pcWb            (pcWb),
        .memReadDataWb   (memReadDataWb),
        .regWriteAddrWb  (regWriteAddrWb),
        .regWriteDataWb  (regWriteDataWb)
    );

endmodule

// ==== hw/memWbRegister.sv ====
/*
 * MEM/WB pipeline register with write-back data selection.
 * Reset and clr clear every output and win over stall.
 * All-zero outputs read as a nop that writes no register.
 */

module memWbRegister (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             stall,
    input  logic                             clr,
    input  mipsPkg::memClass                 memKind,
    input  logic [mipsPkg::instrWidth-1:0]   instrMem,
    input  logic [mipsPkg::dataWidth-1:0]    pcMem,
    input  logic [mipsPkg::dataWidth-1:0]    readData,
    input  logic [mipsPkg::regAddrWidth-1:0] regWriteAddrMem,
    input  logic [mipsPkg::dataWidth-1:0]    regWriteDataMem,
    output logic [mipsPkg::instrWidth-1:0]   instrWb,
    output logic [mipsPkg::dataWidth-1:0]    pcWb,
    output logic [mipsPkg::dataWidth-1:0]    memReadDataWb,
    output logic [mipsPkg::regAddrWidth-1:0] regWriteAddrWb,
    output logic [mipsPkg::dataWidth-1:0]    regWriteDataWb
);

    logic [mipsPkg::dataWidth-1:0] writeBackData;

    // Loads hand back the extracted memory value.
    // Everything else keeps the value computed in execute.
    assign writeBackData = (memKind == mipsPkg::memLoad) ? readData : regWriteDataMem;

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            instrWb        <= '0;
            pcWb           <= '0;
            memReadDataWb  <= '0;
            regWriteAddrWb <= '0;
            regWriteDataWb <= '0;
        end else if (!stall) begin
            instrWb        <= instrMem;
            pcWb           <= pcMem;
            memReadDataWb  <= readData;
            regWriteAddrWb <= regWriteAddrMem;
            regWriteDataWb <= writeBackData;
        end
    end

endmodule

// ==== hw/dataMemory.sv ====
/*
 * Word-organized data memory with byte-lane writes and asynchronous read.
 * memDepthWords must be a power of two and at least 2.
 * Addresses wrap modulo the depth and low bits below the access size are ignored.
 * No misalignment or range exceptions are raised.
 */

module dataMemory #(
    parameter int memDepthWords = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          stall,
    input  mipsPkg::memClass              memKind,
    input  mipsPkg::accessSize            accessKind,
    input  logic                          loadSigned,
    input  logic [mipsPkg::dataWidth-1:0] addr,
    input  logic [mipsPkg::dataWidth-1:0] storeData,
    output logic [mipsPkg::dataWidth-1:0] readData
);

    localparam int indexWidth = $clog2(memDepthWords);
    localparam int laneCount  = mipsPkg::dataWidth / 8;

    logic [mipsPkg::dataWidth-1:0] mem [memDepthWords];

    logic [indexWidth-1:0]         wordIndex;
    logic [laneCount-1:0]          byteEnable;
    logic [mipsPkg::dataWidth-1:0] laneData;
    logic [mipsPkg::dataWidth-1:0] readWord;
    logic [7:0]                    readByte;
    logic [15:0]                   readHalf;
    logic                          writeEnable;

    // Bits 1 and 0 pick the byte inside a word.
    // The bits above them index the array, and upper bits simply wrap.
    assign wordIndex = addr[indexWidth+1:2];

    // A stalled store must wait until the stage moves on.
    assign writeEnable = (memKind == mipsPkg::memStore) && !stall;

    // The addressed byte or halfword is copied into every lane,
    // so the lane enables alone decide what lands in memory.
    always_comb begin
        byteEnable = '0;
        laneData   = storeData;
        case (accessKind)
            mipsPkg::sizeByte: begin
                byteEnable = 4'b0001 << addr[1:0];
                laneData   = {laneCount{storeData[7:0]}};
            end
            mipsPkg::sizeHalf: begin
                byteEnable = addr[1] ? 4'b1100 : 4'b0011;
                laneData   = {(laneCount / 2){storeData[15:0]}};
            end
            default: begin
                byteEnable = '1;
            end
        endcase
    end

    // Reset wipes the whole array in one edge.
    // Otherwise each enabled lane is written on its own.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < memDepthWords; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEnable) begin
            for (int lane = 0; lane < laneCount; lane++) begin
                if (byteEnable[lane]) begin
                    mem[wordIndex][lane*8 +: 8] <= laneData[lane*8 +: 8];
                end
            end
        end
    end

    // The read is asynchronous.
    // A load therefore sees the word as it stands before a same-cycle store.
    assign readWord = mem[wordIndex];

    // Byte and halfword selection from the low address bits.
    assign readByte = readWord[addr[1:0]*8 +: 8];
    assign readHalf = addr[1] ? readWord[31:16] : readWord[15:0];

    // Loads extend the selected piece; every other class sees the raw word.
    always_comb begin
        readData = readWord;
        if (memKind == mipsPkg::memLoad) begin
            case (accessKind)
                mipsPkg::sizeByte: begin
                    readData = {{24{loadSigned & readByte[7]}}, readByte};
                end
                mipsPkg::sizeHalf: begin
                    readData = {{16{loadSigned & readHalf[15]}}, readHalf};
                end
                default: begin
                    readData = readWord;
                end
            endcase
        end
    end

endmodule

// ==== hw/storeForward.sv ====
/*
 * Forwarding of the write-back value into the store data.
 * Only the store data operand is covered, not the address.
 * Writes to register 0 are never forwarded.
 */

module storeForward (
    input  logic [mipsPkg::instrWidth-1:0]   instr,
    input  mipsPkg::memClass                 memKind,
    input  logic [mipsPkg::dataWidth-1:0]    memWriteData,
    input  logic [mipsPkg::regAddrWidth-1:0] regAddrWb,
    input  logic [mipsPkg::dataWidth-1:0]    regDataWb,
    output logic [mipsPkg::dataWidth-1:0]    storeData
);

    logic [mipsPkg::regAddrWidth-1:0] rt;
    logic                             forwardHit;

    // A store takes its data from the rt register.
    assign rt = instr[mipsPkg::rtLsb +: mipsPkg::regAddrWidth];

    // The instruction in write-back is newer than the value read in decode,
    // so a match on rt means the execute-stage copy is stale.
    // Register 0 always reads zero, so a match on it must not forward.
    assign forwardHit = (memKind == mipsPkg::memStore)
                     && (regAddrWb != '0)
                     && (regAddrWb == rt);

    assign storeData = forwardHit ? regDataWb : memWriteData;

endmodule

// ==== hw/instrClassifier.sv ====
/*
 * Pure combinational decode of the opcode field.
 * Only lw, lh, lhu, lb, lbu, sw, sh and sb are recognized.
 * Every other opcode is reported as a non-memory word-size access.
 */

module instrClassifier (
    input  logic [mipsPkg::instrWidth-1:0] instr,
    output mipsPkg::memClass               memKind,
    output mipsPkg::accessSize             accessKind,
    output logic                           loadSigned
);

    logic [mipsPkg::opcodeWidth-1:0] opcode;

    // The opcode is the top field of the instruction word.
    assign opcode = instr[mipsPkg::opcodeLsb +: mipsPkg::opcodeWidth];

    always_comb begin
        // Defaults describe a non-memory instruction.
        memKind    = mipsPkg::memNone;
        accessKind = mipsPkg::sizeWord;
        loadSigned = 1'b0;

        case (opcode)
            // Signed loads.
            mipsPkg::opLw: begin
                memKind    = mipsPkg::memLoad;
                accessKind = mipsPkg::sizeWord;
                loadSigned = 1'b1;
            end
            mipsPkg::opLh: begin
                memKind    = mipsPkg::memLoad;
                accessKind = mipsPkg::sizeHalf;
                loadSigned = 1'b1;
            end
            mipsPkg::opLb: begin
                memKind    = mipsPkg::memLoad;
                accessKind = mipsPkg::sizeByte;
                loadSigned = 1'b1;
            end
            // Unsigned loads keep loadSigned low.
            mipsPkg::opLhu: begin
                memKind    = mipsPkg::memLoad;
                accessKind = mipsPkg::sizeHalf;
            end
            mipsPkg::opLbu: begin
                memKind    = mipsPkg::memLoad;
                accessKind = mipsPkg::sizeByte;
            end
            // Stores never extend, so loadSigned stays low.
            mipsPkg::opSw: begin
                memKind    = mipsPkg::memStore;
                accessKind = mipsPkg::sizeWord;
            end
            mipsPkg::opSh: begin
                memKind    = mipsPkg::memStore;
                accessKind = mipsPkg::sizeHalf;
            end
            mipsPkg::opSb: begin
                memKind    = mipsPkg::memStore;
                accessKind = mipsPkg::sizeByte;
            end
            default: ;
        endcase
    end

endmodule

// ==== hw/mipsPkg.sv ====
/*
 * Shared definitions for the MIPS-style memory stage.
 * Field positions follow the standard MIPS I-type layout.
 * Only the eight integer load and store opcodes are named here.
 */

package mipsPkg;

    // Word widths of the datapath.
    localparam int instrWidth   = 32;
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    // The opcode sits in the top six bits of every instruction.
    localparam int opcodeWidth = 6;
    localparam int opcodeLsb   = 26;

    // The rt field of an I-type instruction starts at bit 16.
    localparam int rtLsb = 16;

    // Load opcodes.
    localparam logic [opcodeWidth-1:0] opLb  = 6'h20;
    localparam logic [opcodeWidth-1:0] opLh  = 6'h21;
    localparam logic [opcodeWidth-1:0] opLw  = 6'h23;
    localparam logic [opcodeWidth-1:0] opLbu = 6'h24;
    localparam logic [opcodeWidth-1:0] opLhu = 6'h25;

    // Store opcodes.
    localparam logic [opcodeWidth-1:0] opSb = 6'h28;
    localparam logic [opcodeWidth-1:0] opSh = 6'h29;
    localparam logic [opcodeWidth-1:0] opSw = 6'h2b;

    // Memory class of an instruction.
    // Anything that is not a load or a store is memNone.
    typedef enum logic [1:0] {
        memNone  = 2'd0,
        memLoad  = 2'd1,
        memStore = 2'd2
    } memClass;

    // Access size of a load or a store.
    // Non-memory instructions report sizeWord so the raw word flows through.
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSize;

endpackage
